// File: verilog/cpu_pkg.sv
package cpu_pkg;

   // Datapath and memory sizes
   localparam int data_w = 32;
   localparam int reg_addr_w = 5;
   localparam int mem_addr_w = 10;
   localparam int mem_depth = 1024;

   // Host address bit that picks the control/status register over memory
   localparam int ctrl_sel_bit = 12;

   // Instruction field positions
   localparam int op_hi = 31;
   localparam int op_lo = 27;
   localparam int rd_hi = 26;
   localparam int rd_lo = 22;
   localparam int ra_hi = 21;
   localparam int ra_lo = 17;
   localparam int rb_hi = 16;
   localparam int rb_lo = 12;
   localparam int imm_hi = 15;
   localparam int imm_lo = 0;
   localparam int alu_hi = 3;
   localparam int alu_lo = 0;

   // Zero must stay the NOP so that cleared registers are bubbles
   typedef enum logic [4:0] {
      op_nop      = 5'd0,
      op_load_imm = 5'd1,
      op_alu      = 5'd2,
      op_load     = 5'd3,
      op_store    = 5'd4,
      op_jump     = 5'd5,
      op_halt     = 5'd6
   } opcode_e;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_shl  = 4'd5,
      alu_sltu = 4'd6
   } alu_op_e;

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_halted
   } run_state_e;

endpackage

// File: verilog/run_control.sv
`timescale 1ns/100ps

module run_control (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  logic [cpu_pkg::ctrl_sel_bit:0]  wb_adr,
   input  logic [cpu_pkg::data_w-1:0]      wb_wdata,
   output logic [cpu_pkg::data_w-1:0]      wb_rdata,
   output logic                            wb_ack,
   input  logic                            halt_wb,
   output logic                            run,
   output logic                            start,
   output logic                            host_we,
   output logic [cpu_pkg::mem_addr_w-1:0]  host_addr,
   output logic [cpu_pkg::data_w-1:0]      host_wdata,
   input  logic [cpu_pkg::data_w-1:0]      mem_rdata
);

   cpu_pkg::run_state_e state;
   logic req;
   logic ctrl_sel;
   logic [cpu_pkg::data_w-1:0] status;

   // A bus cycle counts once, on the cycle before its ack
   assign req = wb_cyc && wb_stb && !wb_ack;
   assign ctrl_sel = wb_adr[cpu_pkg::ctrl_sel_bit];

   assign run = (state == cpu_pkg::st_run);
   assign start = req && wb_we && ctrl_sel && wb_wdata[0] && !run;

   // Host memory writes are dropped while the core owns the memory
   assign host_we = req && wb_we && !ctrl_sel && !run;
   assign host_addr = wb_adr[cpu_pkg::mem_addr_w-1:0];
   assign host_wdata = wb_wdata;

   // Bit 0 running, bit 1 halted
   assign status = {{(cpu_pkg::data_w-2){1'b0}}, state == cpu_pkg::st_halted, run};

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= cpu_pkg::st_idle;
      end else begin
         case (state)
            cpu_pkg::st_idle,
            cpu_pkg::st_halted: begin
               if (start) begin
                  state <= cpu_pkg::st_run;
               end
            end
            cpu_pkg::st_run: begin
               if (halt_wb) begin
                  state <= cpu_pkg::st_halted;
               end
            end
            default: state <= cpu_pkg::st_idle;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req;
      end
   end

   // Read data only matters in the ack cycle
   always_ff @(posedge clk) begin
      if (req) begin
         if (ctrl_sel) begin
            wb_rdata <= status;
         end else if (run) begin
            wb_rdata <= '0;
         end else begin
            wb_rdata <= mem_rdata;
         end
      end
   end

   ack_single_cycle : assert property (
      @(posedge clk) disable iff (!rst) wb_ack |=> !wb_ack
   ) else $error("wb_ack high for two cycles");

endmodule

// File: verilog/program_counter.sv
`timescale 1ns/100ps

module program_counter (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           start,
   input  logic                           run,
   input  logic                           stall,
   input  logic                           halt_issue,
   input  logic                           jump_taken,
   input  logic [cpu_pkg::mem_addr_w-1:0] jump_target,
   output logic [cpu_pkg::mem_addr_w-1:0] fetch_addr
);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         fetch_addr <= '0;
      end else if (start) begin
         fetch_addr <= '0;
      end else if (run) begin
         // A taken jump wins over stall and halt
         if (jump_taken) begin
            fetch_addr <= jump_target;
         end else if (!stall && !halt_issue) begin
            fetch_addr <= fetch_addr + 1'b1;
         end
      end
   end

   // Only start may move the PC while the core is not running
   pc_frozen_when_idle : assert property (
      @(posedge clk) disable iff (!rst) (!run && !start) |=> $stable(fetch_addr)
   ) else $error("PC moved while not running");

endmodule

// File: verilog/stall_detector.sv
`timescale 1ns/100ps

module stall_detector (
   input  logic [cpu_pkg::data_w-1:0] issue_instr,
   input  logic [cpu_pkg::data_w-1:0] decode_instr,
   input  logic [cpu_pkg::data_w-1:0] execute_instr,
   input  logic [cpu_pkg::data_w-1:0] memory_instr,
   output logic                       stall
);

   localparam int op_w = cpu_pkg::op_hi - cpu_pkg::op_lo + 1;

   logic [op_w-1:0] issue_op;
   logic use_a;
   logic use_b;
   logic [cpu_pkg::reg_addr_w-1:0] src_a;
   logic [cpu_pkg::reg_addr_w-1:0] src_b;
   logic [cpu_pkg::reg_addr_w-1:0] dest_d;
   logic [cpu_pkg::reg_addr_w-1:0] dest_e;
   logic [cpu_pkg::reg_addr_w-1:0] dest_m;

   // Register written by an instruction, zero if it writes none
   function automatic logic [cpu_pkg::reg_addr_w-1:0] dest_of(
      input logic [cpu_pkg::data_w-1:0] instr);
      logic [op_w-1:0] op;
      op = instr[cpu_pkg::op_hi:cpu_pkg::op_lo];
      if (op == cpu_pkg::op_load_imm || op == cpu_pkg::op_alu || op == cpu_pkg::op_load) begin
         return instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
      end
      return '0;
   endfunction

   assign issue_op = issue_instr[cpu_pkg::op_hi:cpu_pkg::op_lo];
   assign use_a = issue_op inside {cpu_pkg::op_alu, cpu_pkg::op_load,
                                   cpu_pkg::op_store, cpu_pkg::op_jump};
   assign use_b = issue_op inside {cpu_pkg::op_alu, cpu_pkg::op_store, cpu_pkg::op_jump};

   assign src_a = use_a ? issue_instr[cpu_pkg::ra_hi:cpu_pkg::ra_lo] : '0;
   assign src_b = use_b ? issue_instr[cpu_pkg::rb_hi:cpu_pkg::rb_lo] : '0;

   assign dest_d = dest_of(decode_instr);
   assign dest_e = dest_of(execute_instr);
   assign dest_m = dest_of(memory_instr);

   // Register 0 never causes a hazard
   assign stall = (src_a != '0 && (src_a == dest_d || src_a == dest_e || src_a == dest_m)) ||
                  (src_b != '0 && (src_b == dest_d || src_b == dest_e || src_b == dest_m));

endmodule

// File: verilog/instruction_decoder.sv
`timescale 1ns/100ps

module instruction_decoder (
   input  logic [cpu_pkg::data_w-1:0]     instr,
   output cpu_pkg::opcode_e               opcode,
   output logic [cpu_pkg::reg_addr_w-1:0] rd,
   output logic [cpu_pkg::reg_addr_w-1:0] ra,
   output logic [cpu_pkg::reg_addr_w-1:0] rb,
   output cpu_pkg::alu_op_e               alu_op,
   output logic [cpu_pkg::data_w-1:0]     imm
);

   logic [cpu_pkg::op_hi-cpu_pkg::op_lo:0] op_field;

   assign op_field = instr[cpu_pkg::op_hi:cpu_pkg::op_lo];

   // Codes outside the set decode as NOP
   always_comb begin
      case (op_field)
         cpu_pkg::op_load_imm,
         cpu_pkg::op_alu,
         cpu_pkg::op_load,
         cpu_pkg::op_store,
         cpu_pkg::op_jump,
         cpu_pkg::op_halt: opcode = cpu_pkg::opcode_e'(op_field);
         default:          opcode = cpu_pkg::op_nop;
      endcase
   end

   assign rd = instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
   assign ra = instr[cpu_pkg::ra_hi:cpu_pkg::ra_lo];
   assign rb = instr[cpu_pkg::rb_hi:cpu_pkg::rb_lo];

   assign alu_op = cpu_pkg::alu_op_e'(instr[cpu_pkg::alu_hi:cpu_pkg::alu_lo]);

   // Immediate is zero-extended
   assign imm = {{(cpu_pkg::data_w-cpu_pkg::imm_hi-1){1'b0}},
                 instr[cpu_pkg::imm_hi:cpu_pkg::imm_lo]};

endmodule

// File: verilog/register_file.sv
`timescale 1ns/100ps

module register_file (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cpu_pkg::reg_addr_w-1:0] read_addr_a,
   input  logic [cpu_pkg::reg_addr_w-1:0] read_addr_b,
   input  logic [cpu_pkg::reg_addr_w-1:0] write_addr,
   input  logic [cpu_pkg::data_w-1:0]     write_data,
   input  logic                           write_en,
   output logic [cpu_pkg::data_w-1:0]     read_data_a,
   output logic [cpu_pkg::data_w-1:0]     read_data_b
);

   logic [cpu_pkg::data_w-1:0] regs [2**cpu_pkg::reg_addr_w];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en && write_addr != '0) begin
         regs[write_addr] <= write_data;
      end
   end

   // Write-through so a same-cycle reader sees the new value
   assign read_data_a = (read_addr_a == '0) ? '0 :
                        (write_en && write_addr == read_addr_a) ? write_data : regs[read_addr_a];
   assign read_data_b = (read_addr_b == '0) ? '0 :
                        (write_en && write_addr == read_addr_b) ? write_data : regs[read_addr_b];

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cpu_pkg::data_w-1:0]     instr_in,
   input  logic [cpu_pkg::data_w-1:0]     operand_a,
   input  logic [cpu_pkg::data_w-1:0]     operand_b,
   input  logic                           squash,
   output logic [cpu_pkg::data_w-1:0]     instr_out,
   output logic [cpu_pkg::data_w-1:0]     result,
   output logic [cpu_pkg::data_w-1:0]     store_addr,
   output logic [cpu_pkg::data_w-1:0]     store_data,
   output logic                           jump_taken,
   output logic [cpu_pkg::mem_addr_w-1:0] jump_target
);

   logic [cpu_pkg::data_w-1:0] op_a;
   logic [cpu_pkg::data_w-1:0] op_b;
   logic [cpu_pkg::data_w-1:0] imm;
   logic [cpu_pkg::data_w-1:0] alu_res;
   cpu_pkg::opcode_e opcode;
   cpu_pkg::alu_op_e alu_op;

   // Decode-to-execute register, squashed to a NOP
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         instr_out <= '0;
      end else begin
         instr_out <= squash ? '0 : instr_in;
      end
   end

   always_ff @(posedge clk) begin
      op_a <= operand_a;
      op_b <= operand_b;
   end

   instruction_decoder u_decoder (
      .instr  (instr_out),
      .opcode (opcode),
      .rd     (),
      .ra     (),
      .rb     (),
      .alu_op (alu_op),
      .imm    (imm)
   );

   always_comb begin
      case (alu_op)
         cpu_pkg::alu_add:  alu_res = op_a + op_b;
         cpu_pkg::alu_sub:  alu_res = op_a - op_b;
         cpu_pkg::alu_and:  alu_res = op_a & op_b;
         cpu_pkg::alu_or:   alu_res = op_a | op_b;
         cpu_pkg::alu_xor:  alu_res = op_a ^ op_b;
         cpu_pkg::alu_shl:  alu_res = op_a << op_b[4:0];
         cpu_pkg::alu_sltu: alu_res = {{(cpu_pkg::data_w-1){1'b0}}, op_a < op_b};
         default:           alu_res = '0;
      endcase
   end

   // Loads carry their address as the result
   always_comb begin
      case (opcode)
         cpu_pkg::op_load_imm: result = imm;
         cpu_pkg::op_alu:      result = alu_res;
         cpu_pkg::op_load:     result = op_a;
         default:              result = '0;
      endcase
   end

   assign store_addr = op_b;
   assign store_data = op_a;

   assign jump_taken = (opcode == cpu_pkg::op_jump) && (op_a != '0);
   assign jump_target = op_b[cpu_pkg::mem_addr_w-1:0];

endmodule

// File: verilog/unified_memory.sv
`timescale 1ns/100ps

module unified_memory (
   input  logic                           clk,
   input  logic [cpu_pkg::mem_addr_w-1:0] fetch_addr,
   input  logic [cpu_pkg::mem_addr_w-1:0] data_addr,
   input  logic [cpu_pkg::data_w-1:0]     write_addr,
   input  logic [cpu_pkg::data_w-1:0]     write_data,
   input  logic                           write_en,
   output logic [cpu_pkg::data_w-1:0]     fetch_data,
   output logic [cpu_pkg::data_w-1:0]     data_rdata
);

   logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::mem_depth];

   always_ff @(posedge clk) begin
      if (write_en) begin
         mem[write_addr[cpu_pkg::mem_addr_w-1:0]] <= write_data;
      end
   end

   // Both reads are combinational
   assign fetch_data = mem[fetch_addr];
   assign data_rdata = mem[data_addr];

   // Store addresses come from full registers and must fit the array
   write_in_range : assert property (
      @(posedge clk) write_en |-> (write_addr < cpu_pkg::mem_depth)
   ) else $error("memory write to address %0h out of range", write_addr);

endmodule

// File: verilog/cpu_pipelined.sv
`timescale 1ns/100ps

module cpu_pipelined (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [cpu_pkg::ctrl_sel_bit:0] wb_adr,
   input  logic [cpu_pkg::data_w-1:0]     wb_wdata,
   output logic [cpu_pkg::data_w-1:0]     wb_rdata,
   output logic                           wb_ack
);

   localparam int dw = cpu_pkg::data_w;
   localparam int aw = cpu_pkg::mem_addr_w;

   logic run;
   logic start;
   logic host_we;
   logic [aw-1:0] host_addr;
   logic [dw-1:0] host_wdata;
   logic [aw-1:0] fetch_addr;
   logic [dw-1:0] fetch_data;
   logic [dw-1:0] data_rdata;
   logic [aw-1:0] data_addr;
   logic [dw-1:0] mem_write_addr;
   logic [dw-1:0] mem_write_data;
   logic mem_write_en;
   logic [dw-1:0] issue_instr;
   cpu_pkg::opcode_e issue_op;
   logic [cpu_pkg::reg_addr_w-1:0] ra;
   logic [cpu_pkg::reg_addr_w-1:0] rb;
   logic [dw-1:0] read_a;
   logic [dw-1:0] read_b;
   logic stall;
   logic halt_issue;
   logic [dw-1:0] exec_instr;
   logic [dw-1:0] exec_result;
   logic [dw-1:0] store_addr;
   logic [dw-1:0] store_data;
   logic jump_taken;
   logic [aw-1:0] jump_target;
   logic [dw-1:0] mem_instr;
   logic [dw-1:0] mem_result;
   logic [dw-1:0] mem_store_addr;
   logic [dw-1:0] mem_store_data;
   logic [dw-1:0] wb_instr;
   logic [dw-1:0] wb_data;
   logic [cpu_pkg::op_hi-cpu_pkg::op_lo:0] mem_op;
   logic [cpu_pkg::op_hi-cpu_pkg::op_lo:0] wb_op;
   logic rf_we;

   run_control u_run_control (
      .clk(clk), .rst(rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
      .halt_wb(wb_op == cpu_pkg::op_halt), .run(run), .start(start),
      .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
      .mem_rdata(data_rdata)
   );

   program_counter u_program_counter (
      .clk(clk), .rst(rst), .start(start), .run(run), .stall(stall),
      .halt_issue(halt_issue), .jump_taken(jump_taken), .jump_target(jump_target),
      .fetch_addr(fetch_addr)
   );

   // Issue register. Halt sits here and keeps the front end frozen
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         issue_instr <= '0;
      end else if (!run || jump_taken) begin
         issue_instr <= '0;
      end else if (!stall && !halt_issue) begin
         issue_instr <= fetch_data;
      end
   end

   instruction_decoder u_instruction_decoder (
      .instr(issue_instr), .opcode(issue_op), .rd(), .ra(ra), .rb(rb),
      .alu_op(), .imm()
   );

   assign halt_issue = (issue_op == cpu_pkg::op_halt);

   stall_detector u_stall_detector (
      .issue_instr(issue_instr), .decode_instr(exec_instr),
      .execute_instr(mem_instr), .memory_instr(wb_instr), .stall(stall)
   );

   register_file u_register_file (
      .clk(clk), .rst(rst), .read_addr_a(ra), .read_addr_b(rb),
      .write_addr(wb_instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo]), .write_data(wb_data),
      .write_en(rf_we), .read_data_a(read_a), .read_data_b(read_b)
   );

   // Stall sends a bubble into execute
   execute_unit u_execute_unit (
      .clk(clk), .rst(rst), .instr_in(stall ? '0 : issue_instr),
      .operand_a(read_a), .operand_b(read_b), .squash(jump_taken || !run),
      .instr_out(exec_instr), .result(exec_result), .store_addr(store_addr),
      .store_data(store_data), .jump_taken(jump_taken), .jump_target(jump_target)
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mem_instr <= '0;
         wb_instr <= '0;
      end else begin
         mem_instr <= run ? exec_instr : '0;
         wb_instr <= run ? mem_instr : '0;
      end
   end

   always_ff @(posedge clk) begin
      mem_result <= exec_result;
      mem_store_addr <= store_addr;
      mem_store_data <= store_data;
      wb_data <= (mem_op == cpu_pkg::op_load) ? data_rdata : mem_result;
   end

   assign mem_op = mem_instr[cpu_pkg::op_hi:cpu_pkg::op_lo];
   assign wb_op = wb_instr[cpu_pkg::op_hi:cpu_pkg::op_lo];
   assign rf_we = wb_op inside {cpu_pkg::op_load_imm, cpu_pkg::op_alu, cpu_pkg::op_load};

   // Memory data port belongs to the host unless a run is on
   assign data_addr = run ? mem_result[aw-1:0] : host_addr;
   assign mem_write_en = run ? (mem_op == cpu_pkg::op_store) : host_we;
   assign mem_write_addr = run ? mem_store_addr : {{(dw-aw){1'b0}}, host_addr};
   assign mem_write_data = run ? mem_store_data : host_wdata;

   unified_memory u_unified_memory (
      .clk(clk), .fetch_addr(fetch_addr), .data_addr(data_addr),
      .write_addr(mem_write_addr), .write_data(mem_write_data),
      .write_en(mem_write_en), .fetch_data(fetch_data), .data_rdata(data_rdata)
   );

endmodule

// File: test/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] encode_instr(input cpu_pkg::opcode_e op, input logic [4:0] rd,
                                             input logic [4:0] ra, input logic [4:0] rb,
                                             input logic [15:0] low);
   // Immediate and rb overlap, each program uses only one of them
   return {op, rd, ra, 17'd0} | {15'd0, rb, 12'd0} | {16'd0, low};
endfunction

function automatic logic [31:0] li_instr(input logic [4:0] rd, input logic [15:0] imm);
   return encode_instr(cpu_pkg::op_load_imm, rd, 5'd0, 5'd0, imm);
endfunction

function automatic logic [31:0] alu_instr(input cpu_pkg::alu_op_e op, input logic [4:0] rd,
                                          input logic [4:0] ra, input logic [4:0] rb);
   return encode_instr(cpu_pkg::op_alu, rd, ra, rb, {12'd0, op});
endfunction

function automatic logic [31:0] ld_instr(input logic [4:0] rd, input logic [4:0] ra);
   return encode_instr(cpu_pkg::op_load, rd, ra, 5'd0, 16'd0);
endfunction

function automatic logic [31:0] st_instr(input logic [4:0] ra, input logic [4:0] rb);
   return encode_instr(cpu_pkg::op_store, 5'd0, ra, rb, 16'd0);
endfunction

function automatic logic [31:0] jump_instr(input logic [4:0] ra, input logic [4:0] rb);
   return encode_instr(cpu_pkg::op_jump, 5'd0, ra, rb, 16'd0);
endfunction

function automatic logic [31:0] halt_instr();
   return encode_instr(cpu_pkg::op_halt, 5'd0, 5'd0, 5'd0, 16'd0);
endfunction

// Expected ALU results
function automatic logic [31:0] alu_model(input cpu_pkg::alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
   case (op)
      cpu_pkg::alu_add:  return a + b;
      cpu_pkg::alu_sub:  return a - b;
      cpu_pkg::alu_and:  return a & b;
      cpu_pkg::alu_or:   return a | b;
      cpu_pkg::alu_xor:  return a ^ b;
      cpu_pkg::alu_shl:  return a << b[4:0];
      cpu_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      default:           return 32'd0;
   endcase
endfunction

function automatic logic [31:0] mem_pattern(input logic [12:0] addr);
   return {3'b000, addr, 3'b101, addr};
endfunction

task automatic build_table();
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] r3;
   logic [31:0] r4;
   logic [31:0] r5;
   logic [31:0] r6;

   add_row(4'd1, row_status, ctrl_addr, '0, 32'd0);

   for (int i = 0; i < 8; i++) begin
      add_row(4'd2, row_write, 13'(32'h300 + i), mem_pattern(13'(32'h300 + i)), '0);
   end
   for (int i = 0; i < 8; i++) begin
      add_row(4'd2, row_read, 13'(32'h300 + i), '0, mem_pattern(13'(32'h300 + i)));
   end

   // Each alu result feeds the next one
   a = 32'h0000_0123;
   b = 32'h0000_0f0f;
   r3 = alu_model(cpu_pkg::alu_add, a, b);
   r4 = alu_model(cpu_pkg::alu_xor, r3, b);
   r5 = alu_model(cpu_pkg::alu_sub, r4, a);
   r6 = alu_model(cpu_pkg::alu_shl, r5, a);
   code_addr = 0;
   emit_code(4'd3, li_instr(5'd1, a[15:0]));
   emit_code(4'd3, li_instr(5'd2, b[15:0]));
   emit_code(4'd3, alu_instr(cpu_pkg::alu_add, 5'd3, 5'd1, 5'd2));
   emit_code(4'd3, alu_instr(cpu_pkg::alu_xor, 5'd4, 5'd3, 5'd2));
   emit_code(4'd3, alu_instr(cpu_pkg::alu_sub, 5'd5, 5'd4, 5'd1));
   emit_code(4'd3, alu_instr(cpu_pkg::alu_shl, 5'd6, 5'd5, 5'd1));
   emit_code(4'd3, li_instr(5'd7, 16'h0100));
   emit_code(4'd3, li_instr(5'd8, 16'h0101));
   emit_code(4'd3, li_instr(5'd9, 16'h0102));
   emit_code(4'd3, st_instr(5'd3, 5'd7));
   emit_code(4'd3, st_instr(5'd5, 5'd8));
   emit_code(4'd3, st_instr(5'd6, 5'd9));
   emit_code(4'd3, halt_instr());
   for (int i = 0; i < 3; i++) begin
      add_row(4'd3, row_write, 13'(32'h100 + i), '0, '0);
   end
   add_row(4'd3, row_run, ctrl_addr, '0, 32'd2);
   add_row(4'd3, row_read, 13'h100, '0, r3);
   add_row(4'd3, row_read, 13'h101, '0, r5);
   add_row(4'd3, row_read, 13'h102, '0, r6);

   code_addr = 0;
   emit_code(4'd4, li_instr(5'd1, 16'h0180));
   emit_code(4'd4, li_instr(5'd2, 16'h0456));
   emit_code(4'd4, ld_instr(5'd3, 5'd1));
   emit_code(4'd4, alu_instr(cpu_pkg::alu_add, 5'd4, 5'd3, 5'd2));
   emit_code(4'd4, li_instr(5'd5, 16'h0181));
   emit_code(4'd4, st_instr(5'd4, 5'd5));
   emit_code(4'd4, halt_instr());
   add_row(4'd4, row_write, 13'h180, 32'h1111_2222, '0);
   add_row(4'd4, row_write, 13'h181, '0, '0);
   add_row(4'd4, row_run, ctrl_addr, '0, 32'd2);
   add_row(4'd4, row_read, 13'h181, '0, 32'h1111_2222 + 32'h0456);
   add_row(4'd4, row_status, ctrl_addr, '0, 32'd2);

   // Taken jump from 4 to 6 skips the store at 5
   code_addr = 0;
   emit_code(4'd5, li_instr(5'd1, 16'h0001));
   emit_code(4'd5, li_instr(5'd2, 16'h0006));
   emit_code(4'd5, li_instr(5'd3, 16'h1234));
   emit_code(4'd5, li_instr(5'd4, 16'h0200));
   emit_code(4'd5, jump_instr(5'd1, 5'd2));
   emit_code(4'd5, st_instr(5'd3, 5'd4));
   emit_code(4'd5, li_instr(5'd5, 16'h0201));
   emit_code(4'd5, jump_instr(5'd0, 5'd2));
   emit_code(4'd5, st_instr(5'd3, 5'd5));
   emit_code(4'd5, halt_instr());
   add_row(4'd5, row_write, 13'h200, 32'hcafe_0200, '0);
   add_row(4'd5, row_write, 13'h201, '0, '0);
   add_row(4'd5, row_run, ctrl_addr, '0, 32'd2);
   add_row(4'd5, row_read, 13'h200, '0, 32'hcafe_0200);
   add_row(4'd5, row_read, 13'h201, '0, 32'h0000_1234);

   random_bits(16, a);
   random_bits(16, b);
   code_addr = 0;
   emit_code(4'd6, li_instr(5'd1, a[15:0]));
   emit_code(4'd6, li_instr(5'd2, b[15:0]));
   for (int k = 0; k < 7; k++) begin
      emit_code(4'd6, alu_instr(cpu_pkg::alu_op_e'(4'(k)), 5'(3 + k), 5'd1, 5'd2));
   end
   for (int k = 0; k < 7; k++) begin
      emit_code(4'd6, li_instr(5'(10 + k), 16'(32'h140 + k)));
   end
   for (int k = 0; k < 7; k++) begin
      emit_code(4'd6, st_instr(5'(3 + k), 5'(10 + k)));
   end
   emit_code(4'd6, halt_instr());
   for (int k = 0; k < 7; k++) begin
      add_row(4'd6, row_write, 13'(32'h140 + k), 32'hffff_ffff, '0);
   end
   add_row(4'd6, row_run, ctrl_addr, '0, 32'd2);
   for (int k = 0; k < 7; k++) begin
      add_row(4'd6, row_read, 13'(32'h140 + k), '0,
              alu_model(cpu_pkg::alu_op_e'(4'(k)), a, b));
   end
endtask

`endif

// File: test/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

   localparam int ack_timeout = 20;
   localparam int run_timeout = 500;
   localparam logic [cpu_pkg::ctrl_sel_bit:0] ctrl_addr = {1'b1, {cpu_pkg::ctrl_sel_bit{1'b0}}};

   typedef enum logic [1:0] {
      row_write,
      row_read,
      row_run,
      row_status
   } row_kind_e;

   // One host action and the value it should give back
   typedef struct packed {
      logic [3:0]                     test;
      row_kind_e                      kind;
      logic [cpu_pkg::ctrl_sel_bit:0] addr;
      logic [31:0]                    data;
      logic [31:0]                    expected;
   } row_t;

   logic clk;
   logic rst;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [cpu_pkg::ctrl_sel_bit:0] wb_adr;
   logic [31:0] wb_wdata;
   logic [31:0] wb_rdata;
   logic wb_ack;

   row_t rows[$];
   int errors;
   int checks;
   int tests_run;
   int test_start_errors;
   int code_addr;
   logic [31:0] lfsr_state;

   cpu_pipelined u_cpu_pipelined (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end
      return state >> 1;
   endfunction

   task automatic random_bits(input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic add_row(input logic [3:0] test, input row_kind_e kind,
                          input logic [cpu_pkg::ctrl_sel_bit:0] addr,
                          input logic [31:0] data, input logic [31:0] expected);
      row_t row;
      row.test = test;
      row.kind = kind;
      row.addr = addr;
      row.data = data;
      row.expected = expected;
      rows.push_back(row);
   endtask

   // Program words go to consecutive addresses from zero
   task automatic emit_code(input logic [3:0] test, input logic [31:0] word);
      add_row(test, row_write, 13'(code_addr), word, '0);
      code_addr++;
   endtask

   task automatic bus_transfer(input logic we, input logic [cpu_pkg::ctrl_sel_bit:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata);
      int cycles;
      logic acked;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = addr;
      wb_wdata = data;
      cycles = 0;
      acked = 1'b0;
      while (!acked && cycles < ack_timeout) begin
         @(posedge clk);
         #1;
         cycles++;
         acked = wb_ack;
      end
      rdata = wb_rdata;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      if (!acked) begin
         $display("No Wishbone ack for address %h within %0d cycles", addr, ack_timeout);
         errors++;
      end else begin
         check_value("ack_latency", 32'(cycles), 32'd1);
      end
      // Idle cycle between bus cycles
      @(posedge clk);
      #1;
      check_value("wb_ack", 32'(wb_ack), 32'd0);
   endtask

   task automatic write_word(input logic [cpu_pkg::ctrl_sel_bit:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      bus_transfer(1'b1, addr, data, unused);
   endtask

   task automatic read_word(input logic [cpu_pkg::ctrl_sel_bit:0] addr, output logic [31:0] data);
      bus_transfer(1'b0, addr, '0, data);
   endtask

   task automatic run_program(input logic [31:0] expected);
      logic [31:0] status;
      int polls;
      logic done;
      write_word(ctrl_addr, 32'd1);
      polls = 0;
      done = 1'b0;
      while (!done && polls < run_timeout) begin
         read_word(ctrl_addr, status);
         polls++;
         done = status[1];
      end
      if (!done) begin
         $display("Program did not halt within %0d status polls", run_timeout);
         errors++;
      end else begin
         check_value("status", status, expected);
      end
   endtask

   task automatic apply_row(input row_t row);
      logic [31:0] value;
      case (row.kind)
         row_write: write_word(row.addr, row.data);
         row_read: begin
            read_word(row.addr, value);
            check_value($sformatf("mem[%h]", row.addr), value, row.expected);
         end
         row_status: begin
            read_word(ctrl_addr, value);
            check_value("status", value, row.expected);
         end
         default: run_program(row.expected);
      endcase
   endtask

   function automatic string test_name(input logic [3:0] test);
      case (test)
         4'd1: return "status and ack after reset";
         4'd2: return "memory write and read back";
         4'd3: return "dependent alu chain";
         4'd4: return "load add store";
         4'd5: return "taken and not-taken jumps";
         4'd6: return "random alu operations";
         default: return "unknown";
      endcase
   endfunction

   `include "tb_programs.svh"

   initial begin
      rst = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_wdata = '0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      test_start_errors = 0;
      code_addr = 0;
      lfsr_state = 32'd97539;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b1;
      @(posedge clk);
      #1;
      for (int i = 0; i < rows.size(); i++) begin
         apply_row(rows[i]);
         // Report when the next row belongs to another test
         if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
            $display("Test %0d %s: %s, %0d errors", rows[i].test, test_name(rows[i].test),
                     (errors == test_start_errors) ? "passed" : "failed",
                     errors - test_start_errors);
            test_start_errors = errors;
            tests_run++;
         end
      end
      $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+test
verilog/cpu_pkg.sv
verilog/run_control.sv
verilog/program_counter.sv
verilog/stall_detector.sv
verilog/instruction_decoder.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/unified_memory.sv
verilog/cpu_pipelined.sv
test/tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f project.f \
   && ./obj_dir/Vtb_cpu | tee sim.log \
   || { echo "Build or simulation failed"; exit 1; }
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
